// File: design/cfg_cmd_decoder.sv
`timescale 1ns/1ps

module cfg_cmd_decoder
    import pcie_cfg_pkg::*;
(
    input  logic        clk_pcie,
    input  logic        rst,
    input  logic        i_cmd_valid,
    input  cmd_word_t   i_cmd,
    input  logic        i_rsp_almost_full,
    input  logic        i_wait_complete,
    input  logic        i_mgmt_pending,
    output logic        o_cmd_rd_en,
    output logic        o_rd_strobe,
    output logic        o_wr_strobe,
    output logic [15:0] o_address,
    output logic [15:0] o_value,
    output logic [15:0] o_mask
);

    logic [1:0] pace_cnt;
    logic       stall;

    // --------------------
    // Command pacing
    // --------------------
    // Two idle cycles in four give a started access time to show up
    // as pending before the next command is fetched
    always_ff @(posedge clk_pcie)
    begin
        if (rst)
            pace_cnt <= 2'd0;
        else
            pace_cnt <= pace_cnt + 2'd1;
    end

    assign stall       = i_rsp_almost_full | (i_wait_complete & i_mgmt_pending);
    assign o_cmd_rd_en = pace_cnt[1] & ~stall;

    // --------------------
    // Field decode
    // --------------------
    assign o_rd_strobe = i_cmd_valid & i_cmd.flags.rd;
    assign o_wr_strobe = i_cmd_valid & i_cmd.flags.wr & i_cmd.address[15];  // RW file only

    assign o_address = i_cmd.address;
    assign o_value   = {i_cmd.value[7:0], i_cmd.value[15:8]};   // Swap to little endian
    assign o_mask    = {i_cmd.mask[7:0], i_cmd.mask[15:8]};

endmodule

// File: design/cfg_mgmt_seq.sv
`timescale 1ns/1ps

module cfg_mgmt_seq
    import pcie_cfg_pkg::*;
(
    input  logic         clk_pcie,
    input  logic         rst,
    input  logic         i_start_rd,
    input  logic         i_start_wr,
    input  mgmt_req_t    i_mgmt_req,
    input  logic         i_mgmt_done,
    input  logic [31:0]  i_mgmt_do,
    output logic         o_mgmt_rd_en,
    output logic         o_mgmt_wr_en,
    output logic         o_rd_ack,
    output logic         o_wr_ack,
    output logic         o_busy,
    output mgmt_result_t o_result
);

    mgmt_state_e state;
    logic        idle;

    assign idle = (state == IDLE);

    // Done wins over a new start, read start over write start
    assign o_rd_ack = idle & ~i_mgmt_done & i_start_rd;
    assign o_wr_ack = idle & ~i_mgmt_done & ~i_start_rd & i_start_wr;

    always_ff @(posedge clk_pcie)
    begin
        if (rst)
            state <= IDLE;
        else if (i_mgmt_done)
            state <= IDLE;
        else if (o_rd_ack)
            state <= READING;
        else if (o_wr_ack)
            state <= WRITING;
    end

    // --------------------
    // Result capture
    // --------------------
    always_ff @(posedge clk_pcie)
    begin
        if (rst)
        begin
            o_result <= '0;
        end
        else if (i_mgmt_done)
        begin
            o_result.valid   <= 1'b1;
            o_result.dwaddr  <= i_mgmt_req.dwaddr;
            o_result.byte_en <= i_mgmt_req.byte_en;
            o_result.data    <= i_mgmt_do;
        end
        else if (o_rd_ack || o_wr_ack)
        begin
            o_result.valid   <= 1'b0;               // Stale until the next done
        end
    end

    assign o_mgmt_rd_en = (state == READING) & ~i_mgmt_done;
    assign o_mgmt_wr_en = (state == WRITING) & ~i_mgmt_done;
    assign o_busy       = ~idle;

endmodule

// File: design/cfg_reg_file.sv
`timescale 1ns/1ps

module cfg_reg_file
    import pcie_cfg_pkg::*;
(
    input  logic         clk_pcie,
    input  logic         rst,
    input  logic         i_rd_strobe,
    input  logic         i_wr_strobe,
    input  logic [15:0]  i_address,
    input  logic [15:0]  i_value,
    input  logic [15:0]  i_mask,
    input  logic         i_rd_ack,
    input  logic         i_wr_ack,
    input  logic         i_preset_load,
    input  mgmt_result_t i_mgmt_result,
    input  logic         i_mgmt_rd_en,
    input  logic         i_mgmt_wr_en,
    output logic         o_rsp_valid,
    output rsp_word_t    o_rsp,
    output mgmt_req_t    o_mgmt,
    output logic         o_start_rd,
    output logic         o_start_wr,
    output logic         o_wait_complete,
    output logic         o_status_cl_en,
    output logic         o_command_en,
    output logic [31:0]  o_clr_ticks
);

    logic [RW_BITS-1:0] rw;
    logic [RO_BITS-1:0] ro;
    logic [17:0]        bit_addr;
    logic               sel_rw;
    logic [RW_BITS-1:0] wr_mask;
    logic [RW_BITS-1:0] wr_data;
    logic [15:0]        rd_data;
    mgmt_req_t          clr_req;

    // --------------------
    // Read-only view
    // --------------------
    assign ro = {
        i_mgmt_result,                              // +00A captured result
        16'h0000,                                   // +008 slack
        32'(RO_BITS / 8),                           // +004 byte count
        14'h0000,
        i_mgmt_wr_en,                               // +002 live enables
        i_mgmt_rd_en,
        RO_MAGIC                                    // +000
    };

    assign bit_addr = {i_address[14:0], 3'b000};
    assign sel_rw   = i_address[15];

    // Anything past the end of a file reads as zero
    always_comb
    begin
        rd_data = 16'h0000;
        if (sel_rw && (bit_addr < RW_BITS))
            rd_data = 16'(rw >> bit_addr);
        else if (!sel_rw && (bit_addr < RO_BITS))
            rd_data = 16'(ro >> bit_addr);
    end

    // --------------------
    // Write path
    // --------------------
    assign wr_mask = RW_BITS'(i_mask) << bit_addr;     // Bits past the end drop off
    assign wr_data = RW_BITS'(i_value) << bit_addr;

    always_comb
    begin
        clr_req               = '0;
        clr_req.di            = {CLR_DI_STATUS, CLR_DI_COMMAND};
        clr_req.dwaddr        = CLR_DWADDR;
        clr_req.byte_en[0]    = rw[RWPOS_COMMAND_EN];   // Command register
        clr_req.byte_en[1]    = rw[RWPOS_COMMAND_EN];
        clr_req.byte_en[3]    = rw[RWPOS_STATUS_CL_EN]; // Upper status byte
    end

    always_ff @(posedge clk_pcie)
    begin
        if (rst)
        begin
            rw <= RW_RESET;
        end
        else
        begin
            if (i_wr_strobe)
                rw <= (rw & ~wr_mask) | (wr_data & wr_mask);
            if (i_rd_ack)
                rw[RWPOS_RD_EN] <= 1'b0;
            if (i_wr_ack)
                rw[RWPOS_WR_EN] <= 1'b0;
            if (i_preset_load)
            begin
                rw[RWPOS_MGMT_DI +: $bits(mgmt_req_t)] <= clr_req;
                rw[RWPOS_WR_EN] <= 1'b1;                 // Launch the preset write
            end
        end
    end

    // --------------------
    // Replies
    // --------------------
    always_ff @(posedge clk_pcie)
    begin
        if (rst)
            o_rsp_valid <= 1'b0;
        else
            o_rsp_valid <= i_rd_strobe;
    end

    always_ff @(posedge clk_pcie)
    begin
        if (i_rd_strobe)
        begin
            o_rsp.address <= i_address;
            o_rsp.data    <= {rd_data[7:0], rd_data[15:8]};
        end
    end

    assign o_mgmt          = {rw[RWPOS_MGMT_CTRL +: 16], rw[RWPOS_MGMT_DI +: 32]};
    assign o_start_rd      = rw[RWPOS_RD_EN];
    assign o_start_wr      = rw[RWPOS_WR_EN];
    assign o_wait_complete = rw[RWPOS_WAIT_COMPLETE];
    assign o_status_cl_en  = rw[RWPOS_STATUS_CL_EN];
    assign o_command_en    = rw[RWPOS_COMMAND_EN];
    assign o_clr_ticks     = rw[RWPOS_CLR_TICKS +: 32];

endmodule

// File: design/cfg_status_clear_timer.sv
`timescale 1ns/1ps

module cfg_status_clear_timer
(
    input  logic        clk_pcie,
    input  logic        rst,
    input  logic        i_enable,
    input  logic        i_quiet,
    input  logic [31:0] i_clr_ticks,
    output logic        o_preset_load
);

    logic [31:0] idle_cnt;
    logic        counting;
    logic        expired;

    // Only quiet cycles count; a command or an access freezes the count
    assign counting = i_enable & i_quiet;
    assign expired  = (idle_cnt >= i_clr_ticks);

    always_ff @(posedge clk_pcie)
    begin
        if (rst)
            idle_cnt <= 32'd0;
        else if (counting)
        begin
            if (expired)
                idle_cnt <= 32'd0;                  // Restart after the preset
            else
                idle_cnt <= idle_cnt + 32'd1;
        end
    end

    assign o_preset_load = counting & expired;

endmodule

// File: design/pcie_cfg_ctrl.sv
`timescale 1ns/1ps

module pcie_cfg_ctrl
    import pcie_cfg_pkg::*;
(
    input  logic        i_rst,
    input  logic        i_clk_pcie,
    input  logic        i_cmd_valid,
    input  cmd_word_t   i_cmd,
    output logic        o_cmd_rd_en,
    output logic        o_rsp_valid,
    output rsp_word_t   o_rsp,
    input  logic        i_rsp_almost_full,
    output mgmt_req_t   o_mgmt,
    output logic        o_mgmt_rd_en,
    output logic        o_mgmt_wr_en,
    input  logic        i_mgmt_done,
    input  logic [31:0] i_mgmt_do
);

    logic         rd_strobe;
    logic         wr_strobe;
    logic [15:0]  cmd_address;
    logic [15:0]  cmd_value;
    logic [15:0]  cmd_mask;
    logic         start_rd;
    logic         start_wr;
    logic         wait_complete;
    logic         status_cl_en;
    logic         command_en;
    logic [31:0]  clr_ticks;
    logic         rd_ack;
    logic         wr_ack;
    logic         mgmt_busy;
    mgmt_result_t mgmt_result;
    logic         preset_load;
    logic         mgmt_pending;
    logic         quiet;

    // --------------------
    // Shared idle terms
    // --------------------
    assign mgmt_pending = start_rd | start_wr | mgmt_busy;
    assign quiet        = ~rd_strobe & ~wr_strobe & ~mgmt_pending;

    cfg_cmd_decoder u_cmd_decoder (
        .clk_pcie          (i_clk_pcie),
        .rst               (i_rst),
        .i_cmd_valid       (i_cmd_valid),
        .i_cmd             (i_cmd),
        .i_rsp_almost_full (i_rsp_almost_full),
        .i_wait_complete   (wait_complete),
        .i_mgmt_pending    (mgmt_pending),
        .o_cmd_rd_en       (o_cmd_rd_en),
        .o_rd_strobe       (rd_strobe),
        .o_wr_strobe       (wr_strobe),
        .o_address         (cmd_address),
        .o_value           (cmd_value),
        .o_mask            (cmd_mask)
    );

    cfg_reg_file u_reg_file (
        .clk_pcie        (i_clk_pcie),
        .rst             (i_rst),
        .i_rd_strobe     (rd_strobe),
        .i_wr_strobe     (wr_strobe),
        .i_address       (cmd_address),
        .i_value         (cmd_value),
        .i_mask          (cmd_mask),
        .i_rd_ack        (rd_ack),
        .i_wr_ack        (wr_ack),
        .i_preset_load   (preset_load),
        .i_mgmt_result   (mgmt_result),
        .i_mgmt_rd_en    (o_mgmt_rd_en),
        .i_mgmt_wr_en    (o_mgmt_wr_en),
        .o_rsp_valid     (o_rsp_valid),
        .o_rsp           (o_rsp),
        .o_mgmt          (o_mgmt),
        .o_start_rd      (start_rd),
        .o_start_wr      (start_wr),
        .o_wait_complete (wait_complete),
        .o_status_cl_en  (status_cl_en),
        .o_command_en    (command_en),
        .o_clr_ticks     (clr_ticks)
    );

    cfg_mgmt_seq u_mgmt_seq (
        .clk_pcie     (i_clk_pcie),
        .rst          (i_rst),
        .i_start_rd   (start_rd),
        .i_start_wr   (start_wr),
        .i_mgmt_req   (o_mgmt),
        .i_mgmt_done  (i_mgmt_done),
        .i_mgmt_do    (i_mgmt_do),
        .o_mgmt_rd_en (o_mgmt_rd_en),
        .o_mgmt_wr_en (o_mgmt_wr_en),
        .o_rd_ack     (rd_ack),
        .o_wr_ack     (wr_ack),
        .o_busy       (mgmt_busy),
        .o_result     (mgmt_result)
    );

    cfg_status_clear_timer u_status_clear_timer (
        .clk_pcie      (i_clk_pcie),
        .rst           (i_rst),
        .i_enable      (status_cl_en | command_en),
        .i_quiet       (quiet),
        .i_clr_ticks   (clr_ticks),
        .o_preset_load (preset_load)
    );

endmodule

// File: design/pcie_cfg_pkg.sv
package pcie_cfg_pkg;

    // --------------------
    // Register file sizes
    // --------------------
    localparam int RW_BITS = 160;                   // 20 bytes
    localparam int RO_BITS = 128;                   // 16 bytes

    localparam logic [15:0] RW_MAGIC = 16'h6745;
    localparam logic [15:0] RO_MAGIC = 16'h2301;

    // Control bits, byte 2 of the read-write file
    localparam int RWPOS_RD_EN         = 16;        // Start config read
    localparam int RWPOS_WR_EN         = 17;        // Start config write
    localparam int RWPOS_WAIT_COMPLETE = 18;        // Stall commands while busy
    localparam int RWPOS_STATUS_CL_EN  = 19;        // Periodic status clear
    localparam int RWPOS_COMMAND_EN    = 20;        // Periodic command set

    // Management fields
    localparam int RWPOS_MGMT_DI   = 64;            // +008 data
    localparam int RWPOS_MGMT_CTRL = 96;            // +00C dwaddr, flags, byte enables
    localparam int RWPOS_CLR_TICKS = 128;           // +010 clear timer limit

    localparam logic [31:0] CLR_TICKS_RESET    = 32'd62500;
    localparam logic [3:0]  MGMT_BYTE_EN_RESET = 4'hf;

    // Preset write issued by the clear timer
    localparam logic [9:0]  CLR_DWADDR     = 10'd1;     // Command/status dword
    localparam logic [15:0] CLR_DI_COMMAND = 16'h0007;
    localparam logic [15:0] CLR_DI_STATUS  = 16'hff00;  // Write-one-to-clear bits

    // Read-write file image after reset, from the top byte down
    localparam logic [RW_BITS-1:0] RW_RESET = {
        CLR_TICKS_RESET,                            // +010
        16'h0000,                                   // +00E slack
        MGMT_BYTE_EN_RESET,                         // +00C
        12'h000,
        32'h0000_0000,                              // +008
        32'(RW_BITS / 8),                           // +004 byte count
        16'h0000,                                   // +002 control
        RW_MAGIC                                    // +000
    };

    // --------------------
    // Command and reply words
    // --------------------
    typedef struct packed {
        logic [1:0]  rsvd_hi;
        logic        wr;                            // Bit 13
        logic        rd;                            // Bit 12
        logic [11:0] rsvd_lo;
    } cmd_flags_t;

    typedef struct packed {
        logic [15:0] value;                         // Bytes 6 and 7
        logic [15:0] mask;                          // Bytes 4 and 5
        logic [15:0] address;                       // Top bit selects read-write file
        cmd_flags_t  flags;
    } cmd_word_t;

    typedef struct packed {
        logic [15:0] address;
        logic [15:0] data;
    } rsp_word_t;

    // --------------------
    // Core management port
    // --------------------
    typedef struct packed {
        logic [3:0]  byte_en;
        logic        wr_rw1c_as_rw;
        logic        wr_readonly;
        logic [9:0]  dwaddr;
        logic [31:0] di;
    } mgmt_req_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  byte_en;
        logic        valid;
        logic        rsvd;
        logic [9:0]  dwaddr;
    } mgmt_result_t;

    typedef enum logic [1:0] {
        IDLE,
        READING,
        WRITING
    } mgmt_state_e;

endpackage

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert \
    --top-module pcie_cfg_ctrl_tb \
    -f verilog.f \
    -o Vpcie_cfg_ctrl_tb
./obj_dir/Vpcie_cfg_ctrl_tb

// File: test/pcie_cfg_ctrl_checker.sv
`timescale 1ns/1ps

module pcie_cfg_ctrl_checker
(
    input logic i_clk_pcie,
    input logic i_rst,
    input logic i_rsp_almost_full,
    input logic i_mgmt_done,
    input logic o_rsp_valid,
    input logic o_mgmt_rd_en,
    input logic o_mgmt_wr_en
);

    // Core sees its enables drop in the done cycle
    a_no_en_with_done : assert property (@(posedge i_clk_pcie) disable iff (i_rst)
        !((o_mgmt_rd_en || o_mgmt_wr_en) && i_mgmt_done))
        else $error("management enable high together with done");

    a_one_en : assert property (@(posedge i_clk_pcie) disable iff (i_rst)
        !(o_mgmt_rd_en && o_mgmt_wr_en))
        else $error("read and write enables high together");

    // A reply trails its command fetch by two cycles
    a_no_rsp_when_full : assert property (@(posedge i_clk_pcie) disable iff (i_rst)
        o_rsp_valid |-> !$past(i_rsp_almost_full, 2))
        else $error("reply sent although the sink was almost full");

    a_quiet_after_rst : assert property (@(posedge i_clk_pcie)
        $past(i_rst) |-> (!o_rsp_valid && !o_mgmt_rd_en && !o_mgmt_wr_en))
        else $error("outputs active right after reset");

endmodule

bind pcie_cfg_ctrl pcie_cfg_ctrl_checker u_checker (
    .i_clk_pcie        (i_clk_pcie),
    .i_rst             (i_rst),
    .i_rsp_almost_full (i_rsp_almost_full),
    .i_mgmt_done       (i_mgmt_done),
    .o_rsp_valid       (o_rsp_valid),
    .o_mgmt_rd_en      (o_mgmt_rd_en),
    .o_mgmt_wr_en      (o_mgmt_wr_en)
);

// File: test/pcie_cfg_ctrl_tb.sv
`timescale 1ns/1ps

module pcie_cfg_ctrl_tb
    import pcie_cfg_pkg::*;
();

    localparam time CLK_PERIOD = 100ns;
    localparam int  WAIT_LIMIT = 300;               // Cycles for any single wait

    // Per-test budgets in cycles
    localparam int T_RESET = 10;
    localparam int T_REGS  = 150;
    localparam int T_MASK  = 200;
    localparam int T_READ  = 250;
    localparam int T_WRITE = 250;
    localparam int T_CLEAR = 500;
    localparam int T_BP    = 250;
    localparam int WATCHDOG_CYCLES = T_RESET + T_REGS + T_MASK + T_READ + T_WRITE
                                     + T_CLEAR + T_BP;

    typedef struct packed {
        logic      is_wr;
        mgmt_req_t req;
    } access_t;

    logic        i_rst;
    logic        i_clk_pcie;
    logic        i_cmd_valid;
    cmd_word_t   i_cmd;
    logic        o_cmd_rd_en;
    logic        o_rsp_valid;
    rsp_word_t   o_rsp;
    logic        i_rsp_almost_full;
    mgmt_req_t   o_mgmt;
    logic        o_mgmt_rd_en;
    logic        o_mgmt_wr_en;
    logic        i_mgmt_done;
    logic [31:0] i_mgmt_do;

    cmd_word_t cmd_q[$];
    rsp_word_t rsp_q[$];
    access_t   acc_q[$];
    integer    seed;
    logic      rd_en_d;

    pcie_cfg_ctrl u_pcie_cfg_ctrl (
        .i_rst             (i_rst),
        .i_clk_pcie        (i_clk_pcie),
        .i_cmd_valid       (i_cmd_valid),
        .i_cmd             (i_cmd),
        .o_cmd_rd_en       (o_cmd_rd_en),
        .o_rsp_valid       (o_rsp_valid),
        .o_rsp             (o_rsp),
        .i_rsp_almost_full (i_rsp_almost_full),
        .o_mgmt            (o_mgmt),
        .o_mgmt_rd_en      (o_mgmt_rd_en),
        .o_mgmt_wr_en      (o_mgmt_wr_en),
        .i_mgmt_done       (i_mgmt_done),
        .i_mgmt_do         (i_mgmt_do)
    );

    initial
    begin
        i_clk_pcie = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk_pcie = ~i_clk_pcie;
    end

    // --------------------
    // Helpers
    // --------------------
    function automatic logic [15:0] swap16(input logic [15:0] x);
        return {x[7:0], x[15:8]};
    endfunction

    // Data the core model returns for a dword address
    function automatic logic [31:0] core_data(input logic [9:0] dw);
        return {6'h15, dw, 6'h2a, dw};
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        string line;
        if (exp !== act)
        begin
            line = $sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act);
            fail_run(line);
        end
    endtask

    // Value and mask are given little endian, the wire format swaps them
    task automatic send_cmd(input logic rd, input logic wr, input logic [15:0] addr,
                            input logic [15:0] value, input logic [15:0] mask);
        cmd_word_t c;
        c          = '0;
        c.value    = swap16(value);
        c.mask     = swap16(mask);
        c.address  = addr;
        c.flags.rd = rd;
        c.flags.wr = wr;
        cmd_q.push_back(c);
    endtask

    task automatic expect_reply(input string name, input logic [15:0] addr,
                                input logic [15:0] exp);
        int        n;
        rsp_word_t r;
        n = 0;
        while (rsp_q.size() == 0)
        begin
            @(negedge i_clk_pcie);
            n++;
            if (n > WAIT_LIMIT)
                fail_run($sformatf("No reply arrived in test %s", name));
        end
        r = rsp_q.pop_front();
        check({name, " address"}, 32'(addr), 32'(r.address));
        check({name, " data"}, 32'(swap16(exp)), 32'(r.data));
    endtask

    task automatic read_check(input string name, input logic [15:0] addr,
                              input logic [15:0] exp);
        send_cmd(1'b1, 1'b0, addr, 16'h0000, 16'h0000);
        expect_reply(name, addr, exp);
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [15:0] value,
                             input logic [15:0] mask);
        int n;
        n = 0;
        send_cmd(1'b0, 1'b1, addr, value, mask);
        while (cmd_q.size() != 0)
        begin
            @(negedge i_clk_pcie);
            n++;
            if (n > WAIT_LIMIT)
                fail_run("A write command was never fetched by the DUT");
        end
        repeat (2) @(negedge i_clk_pcie);
    endtask

    task automatic wait_access(input int count);
        int n;
        n = 0;
        while (acc_q.size() < count)
        begin
            @(negedge i_clk_pcie);
            n++;
            if (n > WAIT_LIMIT)
                fail_run("The core model saw no management access in time");
        end
    endtask

    // --------------------
    // Bus models
    // --------------------
    // Command source answers a read enable one cycle later
    initial
    begin
        i_cmd_valid = 1'b0;
        i_cmd       = '0;
        rd_en_d     = 1'b0;
        forever
        begin
            @(posedge i_clk_pcie);
            rd_en_d = o_cmd_rd_en & ~i_rst;     // Enable as the DUT issued it
            @(negedge i_clk_pcie);
            if (rd_en_d && (cmd_q.size() != 0))
            begin
                i_cmd       = cmd_q.pop_front();
                i_cmd_valid = 1'b1;
            end
            else
                i_cmd_valid = 1'b0;
        end
    end

    initial
    begin
        forever
        begin
            @(negedge i_clk_pcie);
            if (o_rsp_valid)
                rsp_q.push_back(o_rsp);
        end
    end

    // Core answers each access after 1 to 4 cycles
    initial
    begin
        access_t a;
        int      delay;
        i_mgmt_done = 1'b0;
        i_mgmt_do   = 32'h0;
        seed        = 5;
        forever
        begin
            @(negedge i_clk_pcie);
            if (!i_rst && (o_mgmt_rd_en || o_mgmt_wr_en))
            begin
                a.is_wr = o_mgmt_wr_en;
                a.req   = o_mgmt;
                delay   = 1 + int'($unsigned($random(seed)) % 4);
                repeat (delay) @(negedge i_clk_pcie);
                i_mgmt_do   = core_data(a.req.dwaddr);
                i_mgmt_done = 1'b1;
                @(negedge i_clk_pcie);
                i_mgmt_done = 1'b0;
                acc_q.push_back(a);
            end
        end
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_run("Watchdog expired before the tests finished");
    end

    // --------------------
    // Directed tests
    // --------------------
    task automatic test_reset_values();
        read_check("reset rw magic", 16'h8000, RW_MAGIC);
        read_check("reset rw bytes", 16'h8004, 16'd20);
        read_check("reset ro magic", 16'h0000, RO_MAGIC);
        read_check("reset ro bytes", 16'h0004, 16'd16);
        read_check("reset byte en", 16'h800c, 16'hf000);
        read_check("reset out of range", 16'h8014, 16'h0000);
    endtask

    task automatic test_masked_write();
        write_reg(16'h8008, 16'h1234, 16'hffff);
        write_reg(16'h8008, 16'habcd, 16'h0ff0);
        read_check("masked write", 16'h8008, 16'h1bc4);
        write_reg(16'h0008, 16'h5a5a, 16'hffff);        // Never strobes
        read_check("ro write ignored", 16'h0008, 16'h0000);
        read_check("rw after ro write", 16'h8008, 16'h1bc4);
    endtask

    task automatic test_config_read();
        logic [31:0] exp_do;
        exp_do = core_data(10'h123);
        write_reg(16'h800c, 16'h0123, 16'h03ff);
        write_reg(16'h8002, 16'h0001, 16'h0001);
        wait_access(1);
        check("cfg read kind", 32'd0, 32'(acc_q[0].is_wr));
        check("cfg read dwaddr", 32'h123, 32'(acc_q[0].req.dwaddr));
        acc_q.delete();
        read_check("cfg read result ctrl", 16'h000a, {4'hf, 1'b1, 1'b0, 10'h123});
        read_check("cfg read data lo", 16'h000c, exp_do[15:0]);
        read_check("cfg read data hi", 16'h000e, exp_do[31:16]);
        read_check("cfg read start clear", 16'h8002, 16'h0000);
    endtask

    task automatic test_config_write();
        write_reg(16'h8008, 16'h5678, 16'hffff);
        write_reg(16'h800a, 16'h9abc, 16'hffff);
        write_reg(16'h800c, 16'h6800, 16'hfc00);        // Byte enables 6, rw1c-as-rw set
        send_cmd(1'b0, 1'b1, 16'h8002, 16'h0006, 16'h0006);
        send_cmd(1'b1, 1'b0, 16'h8008, 16'h0000, 16'h0000);
        send_cmd(1'b1, 1'b0, 16'h800a, 16'h0000, 16'h0000);
        send_cmd(1'b1, 1'b0, 16'h0002, 16'h0000, 16'h0000);
        expect_reply("wait write di lo", 16'h8008, 16'h5678);
        expect_reply("wait write di hi", 16'h800a, 16'h9abc);
        expect_reply("wait write enables", 16'h0002, 16'h0000);  // Held until done
        wait_access(1);
        check("cfg write kind", 32'd1, 32'(acc_q[0].is_wr));
        check("cfg write data", 32'h9abc5678, acc_q[0].req.di);
        check("cfg write byte en", 32'h6, 32'(acc_q[0].req.byte_en));
        check("cfg write readonly", 32'd0, 32'(acc_q[0].req.wr_readonly));
        check("cfg write rw1c", 32'd1, 32'(acc_q[0].req.wr_rw1c_as_rw));
        check("cfg write dwaddr", 32'h123, 32'(acc_q[0].req.dwaddr));
        acc_q.delete();
        write_reg(16'h8002, 16'h0000, 16'h0004);
    endtask

    task automatic test_status_clear();
        int n;
        write_reg(16'h8010, 16'd8, 16'hffff);
        write_reg(16'h8012, 16'd0, 16'hffff);
        acc_q.delete();
        write_reg(16'h8002, 16'h0018, 16'h0018);
        wait_access(1);
        check("clear both kind", 32'd1, 32'(acc_q[0].is_wr));
        check("clear both dwaddr", 32'd1, 32'(acc_q[0].req.dwaddr));
        check("clear both data", 32'hff000007, acc_q[0].req.di);
        check("clear both byte en", 32'b1011, 32'(acc_q[0].req.byte_en));
        // One access may still be in flight with the old enables
        write_reg(16'h8002, 16'h0008, 16'h0018);
        n = acc_q.size();
        wait_access(n + 2);
        check("clear status dwaddr", 32'd1, 32'(acc_q[n + 1].req.dwaddr));
        check("clear status data", 32'hff000007, acc_q[n + 1].req.di);
        check("clear status byte en", 32'b1000, 32'(acc_q[n + 1].req.byte_en));
        write_reg(16'h8002, 16'h0000, 16'h0018);
        repeat (30) @(negedge i_clk_pcie);
        acc_q.delete();
    endtask

    task automatic test_back_pressure();
        i_rsp_almost_full = 1'b1;
        repeat (2) @(negedge i_clk_pcie);
        send_cmd(1'b1, 1'b0, 16'h8000, 16'h0000, 16'h0000);
        send_cmd(1'b1, 1'b0, 16'h8004, 16'h0000, 16'h0000);
        send_cmd(1'b1, 1'b0, 16'h0004, 16'h0000, 16'h0000);
        repeat (20) @(negedge i_clk_pcie);
        check("bp replies held", 32'd0, 32'(rsp_q.size()));
        check("bp commands held", 32'd3, 32'(cmd_q.size()));
        i_rsp_almost_full = 1'b0;
        expect_reply("bp rw magic", 16'h8000, RW_MAGIC);
        expect_reply("bp rw bytes", 16'h8004, 16'd20);
        expect_reply("bp ro bytes", 16'h0004, 16'd16);
    endtask

    initial
    begin
        i_rst             = 1'b1;
        i_rsp_almost_full = 1'b0;
        repeat (3) @(negedge i_clk_pcie);
        i_rst = 1'b0;
        repeat (2) @(negedge i_clk_pcie);

        test_reset_values();
        test_masked_write();
        test_config_read();
        test_config_write();
        test_status_clear();
        test_back_pressure();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: verilog.f
design/pcie_cfg_pkg.sv
design/cfg_cmd_decoder.sv
design/cfg_reg_file.sv
design/cfg_mgmt_seq.sv
design/cfg_status_clear_timer.sv
design/pcie_cfg_ctrl.sv
test/pcie_cfg_ctrl_checker.sv
test/pcie_cfg_ctrl_tb.sv
